/* src/xbar_cfg.svh */
`ifndef XBAR_CFG_SVH
`define XBAR_CFG_SVH

// Width of every address and data word on the fabric.
`define XBAR_DATA_W 32

// Entries in each read-order FIFO and the read limit per master.
`define XBAR_ORDER_DEPTH 4

// Address bit that picks the slave.
`define XBAR_SEL_BIT 30

`endif

/* src/xbar_pkg.sv */
`include "xbar_cfg.svh"

package xbar_pkg;

	// Field view of a bus address. The slave number sits above the select bit.
	typedef struct packed {
		logic [`XBAR_DATA_W-`XBAR_SEL_BIT-2:0] slave;     // Upper slave field.
		logic                                  sel;       // Selects slave 0 or 1.
		logic [`XBAR_SEL_BIT-3:0]              word_idx;  // Word inside the slave.
		logic [1:0]                            byte_off;  // Always zero for word access.
	} xbar_addr_fields_t;

	// One address word seen either as raw bits or as fields.
	typedef union packed {
		logic [`XBAR_DATA_W-1:0] raw;
		xbar_addr_fields_t       f;
	} xbar_addr_u;

	// Identifies one of the two masters.
	typedef logic master_id_t;

	// Identifies one of the two slaves.
	typedef logic slave_id_t;

endpackage

/* src/xbar_slave_arbiter.sv */
`include "xbar_cfg.svh"

module xbar_slave_arbiter import xbar_pkg::*;
(
	input  logic                    memread_grant,
	input  logic                    rst_n_i,
	input  logic [1:0]              req_i,
	input  logic [1:0]              block_i,
	input  logic [`XBAR_DATA_W-1:0] m0_addr_i,
	input  logic                    m0_we_i,
	input  logic [`XBAR_DATA_W-1:0] m0_wdata_i,
	input  logic [`XBAR_DATA_W-1:0] m1_addr_i,
	input  logic                    m1_we_i,
	input  logic [`XBAR_DATA_W-1:0] m1_wdata_i,
	output logic                    s_req_o,
	output logic [`XBAR_DATA_W-1:0] s_addr_o,
	output logic                    s_we_o,
	output logic [`XBAR_DATA_W-1:0] s_wdata_o,
	input  logic                    s_ack_i,
	input  logic                    s_resp_i,
	output logic [1:0]              grant_ack_o,
	output master_id_t              resp_owner_o
);

	localparam int DEPTH = `XBAR_ORDER_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic             locked;
	master_id_t       lock_id;
	master_id_t       rr_ptr;
	logic [1:0]       eligible;
	logic             gnt_valid;
	master_id_t       gnt_id;
	logic             push;
	logic             pop;
	logic             fifo_full;
	master_id_t       order_mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fifo_cnt;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign fifo_full = (fifo_cnt == CNT_W'(DEPTH));

	// A read may only start while the order FIFO has room for its owner.
	assign eligible[0] = req_i[0] & ~block_i[0] & ~(fifo_full & ~m0_we_i);
	assign eligible[1] = req_i[1] & ~block_i[1] & ~(fifo_full & ~m1_we_i);

	always_comb
	begin
		gnt_valid = 1'b0;
		gnt_id    = rr_ptr;
		if (locked)
		begin
			gnt_valid = 1'b1;  // Held grant waits for the slave ack.
			gnt_id    = lock_id;
		end
		else if (eligible[rr_ptr])
		begin
			gnt_valid = 1'b1;
			gnt_id    = rr_ptr;
		end
		else if (eligible[~rr_ptr])
		begin
			gnt_valid = 1'b1;
			gnt_id    = ~rr_ptr;
		end
	end

	assign s_req_o   = gnt_valid;
	assign s_addr_o  = (gnt_id == 1'b1) ? m1_addr_i : m0_addr_i;
	assign s_we_o    = (gnt_id == 1'b1) ? m1_we_i : m0_we_i;
	assign s_wdata_o = (gnt_id == 1'b1) ? m1_wdata_i : m0_wdata_i;

	assign grant_ack_o[0] = s_ack_i & gnt_valid & (gnt_id == 1'b0);
	assign grant_ack_o[1] = s_ack_i & gnt_valid & (gnt_id == 1'b1);

	always_ff @(posedge memread_grant)
	begin
		if (!rst_n_i)
		begin
			locked  <= 1'b0;
			lock_id <= '0;
			rr_ptr  <= '0;
		end
		else if (gnt_valid)
		begin
			if (s_ack_i)
			begin
				locked <= 1'b0;
				rr_ptr <= ~gnt_id;  // The other master goes first next time.
			end
			else
			begin
				locked  <= 1'b1;
				lock_id <= gnt_id;
			end
		end
	end

	assign push = gnt_valid & s_ack_i & ~s_we_o;
	assign pop  = s_resp_i;

	always_ff @(posedge memread_grant)
	begin
		if (push)
			order_mem[wr_ptr] <= gnt_id;
	end

	always_ff @(posedge memread_grant)
	begin
		if (!rst_n_i)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fifo_cnt <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			fifo_cnt <= fifo_cnt + CNT_W'(push) - CNT_W'(pop);
		end
	end

	assign resp_owner_o = order_mem[rd_ptr];  // Oldest read owns the response.

	a_resp_needs_entry: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		s_resp_i |-> (fifo_cnt != '0));

	a_no_push_full: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		push |-> !fifo_full);

	a_req_held: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		(s_req_o && !s_ack_i) |=> (s_req_o && $stable(s_addr_o) && $stable(s_we_o)
			&& $stable(s_wdata_o)));

endmodule

/* src/xbar_resp_merge.sv */
`include "xbar_cfg.svh"

module xbar_resp_merge import xbar_pkg::*;
(
	input  logic                    memread_grant,
	input  logic                    rst_n_i,
	input  logic [1:0]              s0_grant_ack_i,
	input  logic [1:0]              s1_grant_ack_i,
	input  logic                    s0_resp_i,
	input  logic                    s1_resp_i,
	input  master_id_t              s0_owner_i,
	input  master_id_t              s1_owner_i,
	input  logic [`XBAR_DATA_W-1:0] s0_rdata_i,
	input  logic [`XBAR_DATA_W-1:0] s1_rdata_i,
	input  slave_id_t               m0_read_sel_i,
	input  slave_id_t               m1_read_sel_i,
	input  logic                    m0_rd_i,
	input  logic                    m1_rd_i,
	output logic                    m0_ack_o,
	output logic                    m1_ack_o,
	output logic [`XBAR_DATA_W-1:0] m0_rdata_o,
	output logic [`XBAR_DATA_W-1:0] m1_rdata_o,
	output logic                    m0_resp_o,
	output logic                    m1_resp_o,
	output logic [1:0]              s0_block_o,
	output logic [1:0]              s1_block_o
);

	localparam int DEPTH = `XBAR_ORDER_DEPTH;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [1:0]       m_ack;
	logic [1:0]       m_rd;
	logic [1:0]       m_resp;
	logic [1:0]       m_full;
	logic [1:0]       m_pending;
	slave_id_t        m_sel [2];
	logic [CNT_W-1:0] rd_cnt [2];
	slave_id_t        rd_tgt [2];

	// Only one arbiter can grant a master at a time.
	assign m_ack[0] = s0_grant_ack_i[0] | s1_grant_ack_i[0];
	assign m_ack[1] = s0_grant_ack_i[1] | s1_grant_ack_i[1];
	assign m0_ack_o = m_ack[0];
	assign m1_ack_o = m_ack[1];

	assign m_resp[0] = (s0_resp_i & (s0_owner_i == 1'b0)) | (s1_resp_i & (s1_owner_i == 1'b0));
	assign m_resp[1] = (s0_resp_i & (s0_owner_i == 1'b1)) | (s1_resp_i & (s1_owner_i == 1'b1));
	assign m0_resp_o = m_resp[0];
	assign m1_resp_o = m_resp[1];

	// Slave 1 data is picked only when it answers this master.
	assign m0_rdata_o = (s1_resp_i && (s1_owner_i == 1'b0)) ? s1_rdata_i : s0_rdata_i;
	assign m1_rdata_o = (s1_resp_i && (s1_owner_i == 1'b1)) ? s1_rdata_i : s0_rdata_i;

	assign m_rd[0]  = m0_rd_i;
	assign m_rd[1]  = m1_rd_i;
	assign m_sel[0] = m0_read_sel_i;
	assign m_sel[1] = m1_read_sel_i;

	always_ff @(posedge memread_grant)
	begin
		for (int m = 0; m < 2; m++)
		begin
			if (!rst_n_i)
			begin
				rd_cnt[m] <= '0;
				rd_tgt[m] <= '0;
			end
			else
			begin
				if (m_ack[m] && m_rd[m])
					rd_tgt[m] <= m_sel[m];  // All pending reads share this slave.
				rd_cnt[m] <= rd_cnt[m] + CNT_W'(m_ack[m] & m_rd[m]) - CNT_W'(m_resp[m]);
			end
		end
	end

	always_comb
	begin
		for (int m = 0; m < 2; m++)
		begin
			m_full[m]    = (rd_cnt[m] == CNT_W'(DEPTH));
			m_pending[m] = (rd_cnt[m] != '0);
			// Writes never wait here since they return nothing.
			s0_block_o[m] = m_rd[m] & (m_full[m] | (m_pending[m] & (rd_tgt[m] != 1'b0)));
			s1_block_o[m] = m_rd[m] & (m_full[m] | (m_pending[m] & (rd_tgt[m] != 1'b1)));
		end
	end

	a_one_resp_per_master: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		(s0_resp_i && s1_resp_i) |-> (s0_owner_i != s1_owner_i));

	a_m0_no_underflow: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		m_resp[0] |-> m_pending[0]);

	a_m1_no_underflow: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		m_resp[1] |-> m_pending[1]);

endmodule

/* src/xbar_top.sv */
`include "xbar_cfg.svh"

module xbar_top import xbar_pkg::*;
(
	input  logic                    memread_grant,
	input  logic                    rst_n_i,

	input  logic                    m0_req_i,
	input  logic [`XBAR_DATA_W-1:0] m0_addr_i,
	input  logic                    m0_we_i,
	input  logic [`XBAR_DATA_W-1:0] m0_wdata_i,
	output logic                    m0_ack_o,
	output logic [`XBAR_DATA_W-1:0] m0_rdata_o,
	output logic                    m0_resp_o,

	input  logic                    m1_req_i,
	input  logic [`XBAR_DATA_W-1:0] m1_addr_i,
	input  logic                    m1_we_i,
	input  logic [`XBAR_DATA_W-1:0] m1_wdata_i,
	output logic                    m1_ack_o,
	output logic [`XBAR_DATA_W-1:0] m1_rdata_o,
	output logic                    m1_resp_o,

	output logic                    s0_req_o,
	output logic [`XBAR_DATA_W-1:0] s0_addr_o,
	output logic                    s0_we_o,
	output logic [`XBAR_DATA_W-1:0] s0_wdata_o,
	input  logic                    s0_ack_i,
	input  logic [`XBAR_DATA_W-1:0] s0_rdata_i,
	input  logic                    s0_resp_i,

	output logic                    s1_req_o,
	output logic [`XBAR_DATA_W-1:0] s1_addr_o,
	output logic                    s1_we_o,
	output logic [`XBAR_DATA_W-1:0] s1_wdata_o,
	input  logic                    s1_ack_i,
	input  logic [`XBAR_DATA_W-1:0] s1_rdata_i,
	input  logic                    s1_resp_i
);

	xbar_addr_u m0_addr_u;
	xbar_addr_u m1_addr_u;
	slave_id_t  m0_sel;
	slave_id_t  m1_sel;
	logic       m0_rd;
	logic       m1_rd;
	logic [1:0] arb_s0_req;
	logic [1:0] arb_s1_req;
	logic [1:0] s0_block;
	logic [1:0] s1_block;
	logic [1:0] s0_grant_ack;
	logic [1:0] s1_grant_ack;
	master_id_t s0_owner;
	master_id_t s1_owner;

	assign m0_addr_u = m0_addr_i;
	assign m1_addr_u = m1_addr_i;
	assign m0_sel    = m0_addr_u.f.sel;  // Select bit of the address.
	assign m1_sel    = m1_addr_u.f.sel;
	assign m0_rd     = ~m0_we_i;
	assign m1_rd     = ~m1_we_i;

	// Each arbiter sees only the masters that address its slave.
	assign arb_s0_req = {m1_req_i & (m1_sel == 1'b0), m0_req_i & (m0_sel == 1'b0)};
	assign arb_s1_req = {m1_req_i & (m1_sel == 1'b1), m0_req_i & (m0_sel == 1'b1)};

	xbar_slave_arbiter i_arb_s0 (
		.memread_grant(memread_grant), .rst_n_i(rst_n_i),
		.req_i(arb_s0_req), .block_i(s0_block),
		.m0_addr_i(m0_addr_i), .m0_we_i(m0_we_i), .m0_wdata_i(m0_wdata_i),
		.m1_addr_i(m1_addr_i), .m1_we_i(m1_we_i), .m1_wdata_i(m1_wdata_i),
		.s_req_o(s0_req_o), .s_addr_o(s0_addr_o), .s_we_o(s0_we_o), .s_wdata_o(s0_wdata_o),
		.s_ack_i(s0_ack_i), .s_resp_i(s0_resp_i),
		.grant_ack_o(s0_grant_ack), .resp_owner_o(s0_owner)
	);

	xbar_slave_arbiter i_arb_s1 (
		.memread_grant(memread_grant), .rst_n_i(rst_n_i),
		.req_i(arb_s1_req), .block_i(s1_block),
		.m0_addr_i(m0_addr_i), .m0_we_i(m0_we_i), .m0_wdata_i(m0_wdata_i),
		.m1_addr_i(m1_addr_i), .m1_we_i(m1_we_i), .m1_wdata_i(m1_wdata_i),
		.s_req_o(s1_req_o), .s_addr_o(s1_addr_o), .s_we_o(s1_we_o), .s_wdata_o(s1_wdata_o),
		.s_ack_i(s1_ack_i), .s_resp_i(s1_resp_i),
		.grant_ack_o(s1_grant_ack), .resp_owner_o(s1_owner)
	);

	xbar_resp_merge i_merge (
		.memread_grant(memread_grant), .rst_n_i(rst_n_i),
		.s0_grant_ack_i(s0_grant_ack), .s1_grant_ack_i(s1_grant_ack),
		.s0_resp_i(s0_resp_i), .s1_resp_i(s1_resp_i),
		.s0_owner_i(s0_owner), .s1_owner_i(s1_owner),
		.s0_rdata_i(s0_rdata_i), .s1_rdata_i(s1_rdata_i),
		.m0_read_sel_i(m0_sel), .m1_read_sel_i(m1_sel),
		.m0_rd_i(m0_rd), .m1_rd_i(m1_rd),
		.m0_ack_o(m0_ack_o), .m1_ack_o(m1_ack_o),
		.m0_rdata_o(m0_rdata_o), .m1_rdata_o(m1_rdata_o),
		.m0_resp_o(m0_resp_o), .m1_resp_o(m1_resp_o),
		.s0_block_o(s0_block), .s1_block_o(s1_block)
	);

endmodule

/* testbench/tb_slave_model.sv */
`include "xbar_cfg.svh"

module tb_slave_model #(
	parameter logic SLAVE_ID = 1'b0,
	parameter int   SEED     = 1
)
(
	input  logic                    memread_grant,
	input  logic                    rst_n_i,
	input  logic                    req_i,
	input  logic [`XBAR_DATA_W-1:0] addr_i,
	input  logic                    we_i,
	input  logic [`XBAR_DATA_W-1:0] wdata_i,
	input  logic                    hold_i,
	output logic                    ack_o,
	output logic [`XBAR_DATA_W-1:0] rdata_o,
	output logic                    resp_o
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [`XBAR_DATA_W-1:0] mem [64];
	logic [`XBAR_DATA_W-1:0] rq_data [$];  // Read data waiting to be returned.
	int                      rq_delay [$];
	int                      ack_wait;
	int                      seed;

	initial
	begin
		seed = SEED;
		for (int i = 0; i < 64; i++)
			mem[i] = (32'(SLAVE_ID) << 30) + (32'(i) << 2);
	end

	assign ack_o = req_i && (ack_wait == 0);

	always @(posedge memread_grant)
	begin
		resp_o <= 1'b0;
		if (!rst_n_i)
		begin
			ack_wait <= 0;
			rdata_o  <= '0;
			rq_data.delete();
			rq_delay.delete();
		end
		else
		begin
			if (req_i && ack_o)
			begin
				ack_wait <= $random(seed) & 3;  // Delay before the next ack.
				if (we_i)
					mem[addr_i[7:2]] <= wdata_i;
				else
				begin
					rq_data.push_back(mem[addr_i[7:2]]);
					rq_delay.push_back($random(seed) & 3);
				end
			end
			else if (req_i)
				ack_wait <= ack_wait - 1;
			if (rq_data.size() != 0 && !hold_i)
			begin
				if (rq_delay[0] == 0)
				begin
					resp_o  <= 1'b1;
					rdata_o <= rq_data.pop_front();
					void'(rq_delay.pop_front());
				end
				else
					rq_delay[0] = rq_delay[0] - 1;
			end
		end
	end

endmodule

/* testbench/tb_top.sv */
`include "xbar_cfg.svh"

module tb_top import xbar_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT = 200;

	logic memread_grant = 1'b0;
	logic rst_n_i;
	logic m0_req_i, m0_we_i, m0_ack_o, m0_resp_o, m1_req_i, m1_we_i, m1_ack_o, m1_resp_o;
	logic [31:0] m0_addr_i, m0_wdata_i, m0_rdata_o, m1_addr_i, m1_wdata_i, m1_rdata_o;
	logic s0_req_o, s0_we_o, s0_ack_i, s0_resp_i, s1_req_o, s1_we_o, s1_ack_i, s1_resp_i;
	logic [31:0] s0_addr_o, s0_wdata_o, s0_rdata_i, s1_addr_o, s1_wdata_o, s1_rdata_i;
	logic hold_s0, ack_q0, ack_q1, m0_pend, m1_pend, m0_have, m1_have;
	logic [31:0] m0_exp, m1_exp;
	logic [31:0] exp_q0 [$];
	logic [31:0] exp_q1 [$];
	logic [31:0] shadow [logic [31:0]];  // Last data written per address.
	logic [3:0] m0_out, m1_out;
	int m0_skips, m1_skips, seed, mismatch_cnt, fail_cnt;
	string test_name;

	always #20 memread_grant = ~memread_grant;

	xbar_top i_dut (.*);

	tb_slave_model #(.SLAVE_ID(1'b0), .SEED(32'h4f7c_cccd + 1)) i_slave0 (.memread_grant,
		.rst_n_i, .req_i(s0_req_o), .addr_i(s0_addr_o), .we_i(s0_we_o), .wdata_i(s0_wdata_o),
		.hold_i(hold_s0), .ack_o(s0_ack_i), .rdata_o(s0_rdata_i), .resp_o(s0_resp_i));
	tb_slave_model #(.SLAVE_ID(1'b1), .SEED(32'h4f7c_cccd + 2)) i_slave1 (.memread_grant,
		.rst_n_i, .req_i(s1_req_o), .addr_i(s1_addr_o), .we_i(s1_we_o), .wdata_i(s1_wdata_o),
		.hold_i(1'b0), .ack_o(s1_ack_i), .rdata_o(s1_rdata_i), .resp_o(s1_resp_i));

	function automatic logic [31:0] make_addr(input int s, input int w);
		xbar_addr_u u;
		u.raw = '0;
		u.f.sel = s[0];
		u.f.word_idx = 28'(w);
		return u.raw;
	endfunction

	function automatic logic [31:0] preload_word(input logic [31:0] addr);
		xbar_addr_u u;
		u.raw = addr;
		return (32'(u.f.sel) << 30) + (32'(u.f.word_idx) << 2);
	endfunction

	// Acks and read counts seen by the masters, taken at the clock edge.
	always @(posedge memread_grant)
	begin
		ack_q0 <= m0_ack_o;
		ack_q1 <= m1_ack_o;
		if (!rst_n_i)
		begin
			m0_out <= '0;
			m1_out <= '0;
		end
		else
		begin
			m0_out <= m0_out + 4'(m0_ack_o & ~m0_we_i) - 4'(m0_resp_o);
			m1_out <= m1_out + 4'(m1_ack_o & ~m1_we_i) - 4'(m1_resp_o);
		end
		if (!rst_n_i || m0_ack_o || !m0_req_i)
			m0_skips <= 0;
		else if (m1_ack_o && m1_addr_i[30] == m0_addr_i[30])
			m0_skips <= m0_skips + 1;
		if (!rst_n_i || m1_ack_o || !m1_req_i)
			m1_skips <= 0;
		else if (m0_ack_o && m0_addr_i[30] == m1_addr_i[30])
			m1_skips <= m1_skips + 1;
	end

	// The queue head moves one cycle after the response that used it.
	always @(negedge memread_grant)
	begin
		if (m0_pend && exp_q0.size() != 0)
			void'(exp_q0.pop_front());
		if (m1_pend && exp_q1.size() != 0)
			void'(exp_q1.pop_front());
		m0_pend = m0_resp_o;
		m1_pend = m1_resp_o;
		m0_have = (exp_q0.size() != 0);
		m1_have = (exp_q1.size() != 0);
		m0_exp  = m0_have ? exp_q0[0] : '0;
		m1_exp  = m1_have ? exp_q1[0] : '0;
	end

	a_m0_data: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		m0_resp_o |-> (m0_have && m0_rdata_o == m0_exp))
		else
		begin
			if ($sampled(m0_have))
			begin
				mismatch_cnt++;
				$display("mismatch %s m0 expected %h actual %h", test_name, $sampled(m0_exp),
					$sampled(m0_rdata_o));
			end
			else
			begin
				fail_cnt++;
				$display("%s: master 0 got a response with no read outstanding", test_name);
			end
		end
	a_m1_data: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		m1_resp_o |-> (m1_have && m1_rdata_o == m1_exp))
		else
		begin
			if ($sampled(m1_have))
			begin
				mismatch_cnt++;
				$display("mismatch %s m1 expected %h actual %h", test_name, $sampled(m1_exp),
					$sampled(m1_rdata_o));
			end
			else
			begin
				fail_cnt++;
				$display("%s: master 1 got a response with no read outstanding", test_name);
			end
		end
	a_s0_fields: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		(s0_req_o && s0_ack_i) |-> ((m0_ack_o && s0_addr_o == m0_addr_i && s0_we_o == m0_we_i
		&& s0_wdata_o == m0_wdata_i) || (m1_ack_o && s0_addr_o == m1_addr_i
		&& s0_we_o == m1_we_i && s0_wdata_o == m1_wdata_i)))
		else
		begin
			fail_cnt++;
			$display("%s: slave 0 took a request that no master made", test_name);
		end
	a_s1_fields: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		(s1_req_o && s1_ack_i) |-> ((m0_ack_o && s1_addr_o == m0_addr_i && s1_we_o == m0_we_i
		&& s1_wdata_o == m0_wdata_i) || (m1_ack_o && s1_addr_o == m1_addr_i
		&& s1_we_o == m1_we_i && s1_wdata_o == m1_wdata_i)))
		else
		begin
			fail_cnt++;
			$display("%s: slave 1 took a request that no master made", test_name);
		end
	a_fair: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		m0_skips <= 2 && m1_skips <= 2)
		else
		begin
			fail_cnt++;
			$display("%s: a master waited more than two grants", test_name);
		end
	a_limit: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		m0_out <= `XBAR_ORDER_DEPTH && m1_out <= `XBAR_ORDER_DEPTH)
		else
		begin
			fail_cnt++;
			$display("%s: too many reads acked without a response", test_name);
		end
	a_idle: assert property (@(posedge memread_grant) disable iff (!rst_n_i)
		!(m0_req_i || m1_req_i) |-> !(s0_req_o || s1_req_o || m0_ack_o || m1_ack_o))
		else
		begin
			fail_cnt++;
			$display("%s: request or ack active with no master request", test_name);
		end

	// Called at a falling edge; returns at the falling edge after the ack.
	task automatic do_access(input int m, input logic [31:0] addr, input logic we,
		input logic [31:0] wdata);
		int t;
		logic [31:0] exp;
		exp = shadow.exists(addr) ? shadow[addr] : preload_word(addr);
		if (we)
			shadow[addr] = wdata;
		if (m == 0)
		begin
			{m0_req_i, m0_addr_i, m0_we_i, m0_wdata_i} = {1'b1, addr, we, wdata};
			if (!we)
				exp_q0.push_back(exp);
		end
		else
		begin
			{m1_req_i, m1_addr_i, m1_we_i, m1_wdata_i} = {1'b1, addr, we, wdata};
			if (!we)
				exp_q1.push_back(exp);
		end
		for (t = 0; t < TIMEOUT; t++)
		begin
			@(negedge memread_grant);
			if ((m == 0) ? ack_q0 : ack_q1)
				break;
		end
		if (t == TIMEOUT)
		begin
			fail_cnt++;
			$display("%s: master %0d never got an ack", test_name, m);
		end
		if (m == 0)
			m0_req_i = 1'b0;
		else
			m1_req_i = 1'b0;
	endtask

	// Random reads and writes inside the master's own word range.
	task automatic random_traffic(input int m, input int slave, input int n);
		int s;
		for (int i = 0; i < n; i++)
		begin
			s = (slave < 0) ? ($random(seed) & 1) : slave;
			do_access(m, make_addr(s, m * 32 + ($random(seed) & 7)), 1'($random(seed)),
				$random(seed));
		end
	endtask

	// Waits until every read issued so far has returned its data.
	task automatic wait_reads_done();
		int t;
		for (t = 0; t < TIMEOUT; t++)
		begin
			@(negedge memread_grant);
			if (exp_q0.size() == 0 && exp_q1.size() == 0 && !m0_pend && !m1_pend)
				break;
		end
		if (t == TIMEOUT)
		begin
			fail_cnt++;
			$display("%s: reads left without a response", test_name);
		end
	endtask

	initial
	begin
		logic [31:0] d;
		seed = 32'h4f7c_cccd;
		{m0_req_i, m0_we_i, m0_addr_i, m0_wdata_i} = '0;
		{m1_req_i, m1_we_i, m1_addr_i, m1_wdata_i} = '0;
		{hold_s0, m0_pend, m1_pend} = '0;
		mismatch_cnt = 0;
		fail_cnt = 0;
		test_name = "reset";
		rst_n_i = 1'b0;
		repeat (10) @(posedge memread_grant);
		@(negedge memread_grant);
		rst_n_i = 1'b1;
		repeat (3) @(negedge memread_grant);
		if (m0_ack_o || m1_ack_o || m0_resp_o || m1_resp_o || s0_req_o || s1_req_o)
		begin
			fail_cnt++;
			$display("reset: outputs not idle after reset");
		end
		test_name = "reads";
		do_access(0, make_addr(0, 1), 1'b0, '0);
		do_access(0, make_addr(1, 2), 1'b0, '0);
		do_access(1, make_addr(0, 33), 1'b0, '0);
		do_access(1, make_addr(1, 34), 1'b0, '0);
		test_name = "writes";
		for (int s = 0; s < 2; s++)
		begin
			d = $random(seed);
			do_access(0, make_addr(s, 3), 1'b1, d);
			do_access(0, make_addr(s, 3), 1'b0, '0);
			d = $random(seed);
			do_access(1, make_addr(s, 40), 1'b1, d);
			do_access(1, make_addr(s, 40), 1'b0, '0);
		end
		test_name = "contention";
		fork
			random_traffic(0, 0, 8);
			random_traffic(1, 0, 8);
		join
		test_name = "order";
		fork
			for (int i = 0; i < 8; i++)
				do_access(0, make_addr(i % 2, 10 + i), 1'b0, '0);
			random_traffic(1, -1, 8);
		join
		test_name = "limit";
		wait_reads_done();  // The read-order FIFO of slave 0 starts empty.
		hold_s0 = 1'b1;
		fork
			for (int i = 0; i < 5; i++)
				do_access(0, make_addr(0, 20 + i), 1'b0, '0);
			begin
				repeat (30) @(negedge memread_grant);
				hold_s0 = 1'b0;
			end
		join
		test_name = "drain";
		wait_reads_done();
		$display("mismatches %0d, other errors %0d", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* tb.f */
+incdir+src
src/xbar_pkg.sv
src/xbar_slave_arbiter.sv
src/xbar_resp_merge.sv
src/xbar_top.sv
testbench/tb_slave_model.sv
testbench/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the crossbar regression with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_top -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Regression passed$"; then
	exit 0
fi
exit 1
